// File: common/core_pkg.sv
package core_pkg;

    // Command to the instruction cache
    typedef enum logic [0:0] {
        CACHE_CMD_NONE    = 1'b0,
        CACHE_CMD_EXECUTE = 1'b1
    } cache_cmd_t;

    // Cache answer, one value per cycle
    typedef enum logic [2:0] {
        CACHE_RESP_IDLE        = 3'd0,
        CACHE_RESP_WAIT        = 3'd1,
        CACHE_RESP_DONE        = 3'd2,
        CACHE_RESP_MISALIGNED  = 3'd3,
        CACHE_RESP_ACCESSFAULT = 3'd4
    } cache_resp_t;

    // Execute to fetch redirect
    typedef enum logic [0:0] {
        E2F_CMD_NONE        = 1'b0,
        E2F_CMD_BRANCHTAKEN = 1'b1
    } e2f_cmd_t;

    // Machine cause codes used by this core
    typedef enum logic [3:0] {
        INSTR_MISALIGNED   = 4'd0,
        INSTR_ACCESS_FAULT = 4'd1,
        TIMER_IRQ          = 4'd7,
        EXTERNAL_IRQ       = 4'd11
    } trap_cause_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        FETCH_WAIT_RESET,
        FETCH_BUBBLE,
        FETCH_ACTIVE
    } fetch_state_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    // Fetch to decode item, either a word or a trap start
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        logic        exc_start;
        trap_cause_t cause;
    } fetch_out_t;

    // Decode to execute item with operands already read
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] imm;
        alu_op_t     alu_op;
        logic        use_imm;
        logic        is_branch_eq;
        logic        is_branch_ne;
        logic        is_jal;
        logic        exc_start;
        trap_cause_t cause;
    } decoded_t;

    // Execute result heading to the register file
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] wdata;
        logic        is_trap;
        trap_cause_t cause;
    } exec_out_t;

    // Retire report carries the same fields
    typedef exec_out_t retire_t;

    // ADDI x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

// File: fetch/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [31:0]           csr_mtvec,
    input  logic                  irq_timer,
    input  logic                  irq_exti,
    input  logic                  irq_timer_en,
    input  logic                  irq_exti_en,
    input  core_pkg::cache_resp_t c_response,
    input  logic                  c_reset_done,
    input  logic [31:0]           c_load_data,
    output core_pkg::cache_cmd_t  c_cmd,
    output logic [31:0]           c_address,
    output core_pkg::fetch_out_t  fetch_out,
    input  logic                  e2f_ready,
    input  core_pkg::e2f_cmd_t    e2f_cmd,
    input  logic [31:0]           e2f_target
);
    import core_pkg::*;

    fetch_state_t state;
    fetch_state_t state_nxt;
    logic [31:0]  pc;
    logic [31:0]  pc_nxt;
    logic [31:0]  pc_plus_4;
    logic [31:0]  resume_pc;
    logic         cache_done;
    logic         cache_idle;
    logic         cache_fault;
    logic         branch_taken;
    logic         answered;
    logic         new_fetch;
    logic         exti_take;
    logic         timer_take;
    logic         trap_start;
    trap_cause_t  trap_cause;

    assign cache_done   = (c_response == CACHE_RESP_DONE);
    assign cache_idle   = (c_response == CACHE_RESP_IDLE);
    assign cache_fault  = (c_response == CACHE_RESP_MISALIGNED) ||
                          (c_response == CACHE_RESP_ACCESSFAULT);
    assign branch_taken = (e2f_cmd == E2F_CMD_BRANCHTAKEN);
    assign exti_take    = irq_exti && irq_exti_en;
    assign timer_take   = irq_timer && irq_timer_en;
    assign pc_plus_4    = pc + 32'd4;

    // Outstanding command just got its answer
    assign answered = (state == FETCH_ACTIVE) && (cache_done || cache_fault);

    // Redirect skips the hazard wait
    assign new_fetch = (answered || ((state == FETCH_BUBBLE) && cache_idle)) &&
                       (e2f_ready || branch_taken);

    // Where an interrupt returns to
    // Answered word was not executed, otherwise the next one in program order
    assign resume_pc = answered ? pc : (branch_taken ? e2f_target : pc_plus_4);

    // Cache sees the next pc in the same cycle
    assign c_address = pc_nxt;

    always_comb begin
        state_nxt  = state;
        pc_nxt     = pc;
        c_cmd      = CACHE_CMD_NONE;
        trap_start = 1'b0;
        trap_cause = INSTR_MISALIGNED;
        if (state == FETCH_WAIT_RESET) begin
            // Cache still clearing its tags
            if (c_reset_done) begin
                pc_nxt    = RESET_VECTOR;
                c_cmd     = CACHE_CMD_EXECUTE;
                state_nxt = FETCH_ACTIVE;
            end
        end else if (new_fetch) begin
            c_cmd     = CACHE_CMD_EXECUTE;
            state_nxt = FETCH_ACTIVE;
            if (exti_take) begin
                trap_start = 1'b1;
                trap_cause = EXTERNAL_IRQ;
                pc_nxt     = csr_mtvec;
            end else if (timer_take) begin
                trap_start = 1'b1;
                trap_cause = TIMER_IRQ;
                pc_nxt     = csr_mtvec;
            end else if (branch_taken) begin
                pc_nxt = e2f_target;
            end else if (cache_fault) begin
                trap_start = 1'b1;
                trap_cause = (c_response == CACHE_RESP_MISALIGNED) ?
                             INSTR_MISALIGNED : INSTR_ACCESS_FAULT;
                pc_nxt     = csr_mtvec;
            end else begin
                pc_nxt = pc_plus_4;
            end
        end else if (answered) begin
            // Word handed over, hold until decode clears the hazard
            state_nxt = FETCH_BUBBLE;
        end
    end

    // Word goes out in the DONE cycle unless a trap replaces it
    always_comb begin
        fetch_out.valid     = trap_start || ((state == FETCH_ACTIVE) && cache_done);
        fetch_out.pc        = trap_start ? resume_pc : pc;
        fetch_out.instr     = cache_done ? c_load_data : NOP_INSTR;
        fetch_out.exc_start = trap_start;
        fetch_out.cause     = trap_cause;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= FETCH_WAIT_RESET;
            pc    <= RESET_VECTOR;
        end else begin
            state <= state_nxt;
            pc    <= pc_nxt;
        end
    end

    // Cache protocol forbids a new command while one is pending
    assert property (@(posedge clk) disable iff (!rst_n)
        (c_response == CACHE_RESP_WAIT) |-> (c_cmd == CACHE_CMD_NONE));

endmodule

// File: verilog/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  core_pkg::fetch_out_t fetch_out,
    input  logic [31:0]          rs1_data,
    input  logic [31:0]          rs2_data,
    input  logic                 exec_busy_ctrl,
    output logic [4:0]           rs1_addr,
    output logic [4:0]           rs2_addr,
    output core_pkg::decoded_t   dec_out,
    output logic                 e2f_ready
);
    import core_pkg::*;

    logic        slot_valid;
    fetch_out_t  slot;
    logic [31:0] instr;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        op_ok;
    logic        slot_ctrl;

    // BEQ, BNE or JAL by encoding
    function automatic logic is_ctrl(input logic [31:0] word);
        is_ctrl = (word[6:0] == OPC_JAL) ||
                  ((word[6:0] == OPC_BRANCH) && (word[14:13] == 2'b00));
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_valid <= 1'b0;
        end else begin
            slot_valid <= fetch_out.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_out.valid) begin
            slot <= fetch_out;
        end
    end

    assign instr  = slot.instr;
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Register file read happens here, one cycle behind fetch
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'd0};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        // Defaults form a no-op writing x0
        op_ok                = 1'b0;
        dec_out.valid        = slot_valid;
        dec_out.pc           = slot.pc;
        dec_out.rd           = 5'd0;
        dec_out.rs1_val      = rs1_data;
        dec_out.rs2_val      = rs2_data;
        dec_out.imm          = imm_i;
        dec_out.alu_op       = ALU_ADD;
        dec_out.use_imm      = 1'b0;
        dec_out.is_branch_eq = 1'b0;
        dec_out.is_branch_ne = 1'b0;
        dec_out.is_jal       = 1'b0;
        dec_out.exc_start    = slot.exc_start;
        dec_out.cause        = slot.cause;
        if (!slot.exc_start) begin
            case (opcode_t'(instr[6:0]))
                OPC_OP_IMM: begin
                    // Only ADDI
                    dec_out.use_imm = 1'b1;
                    if (funct3 == 3'b000) begin
                        dec_out.rd = instr[11:7];
                    end
                end
                OPC_OP: begin
                    op_ok = 1'b1;
                    case ({funct7, funct3})
                        {7'b0000000, 3'b000}: dec_out.alu_op = ALU_ADD;
                        {7'b0100000, 3'b000}: dec_out.alu_op = ALU_SUB;
                        {7'b0000000, 3'b100}: dec_out.alu_op = ALU_XOR;
                        {7'b0000000, 3'b110}: dec_out.alu_op = ALU_OR;
                        {7'b0000000, 3'b111}: dec_out.alu_op = ALU_AND;
                        default:              op_ok = 1'b0;
                    endcase
                    if (op_ok) begin
                        dec_out.rd = instr[11:7];
                    end
                end
                OPC_LUI: begin
                    dec_out.rd      = instr[11:7];
                    dec_out.imm     = imm_u;
                    dec_out.use_imm = 1'b1;
                    dec_out.alu_op  = ALU_PASS_B;
                end
                OPC_BRANCH: begin
                    dec_out.imm          = imm_b;
                    dec_out.is_branch_eq = (funct3 == 3'b000);
                    dec_out.is_branch_ne = (funct3 == 3'b001);
                end
                OPC_JAL: begin
                    dec_out.rd     = instr[11:7];
                    dec_out.imm    = imm_j;
                    dec_out.is_jal = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    // Fetch holds while any control-flow item is unresolved
    assign slot_ctrl = slot_valid && !slot.exc_start && is_ctrl(instr);
    assign e2f_ready = !(is_ctrl(fetch_out.instr) || slot_ctrl || exec_busy_ctrl);

endmodule

// File: verilog/execute_alu.sv
`timescale 1ns/1ps

module execute_alu (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::decoded_t  dec_out,
    output core_pkg::exec_out_t exec_out,
    output logic                exec_busy_ctrl,
    output core_pkg::e2f_cmd_t  e2f_cmd,
    output logic [31:0]         e2f_target
);
    import core_pkg::*;

    logic        ex_valid;
    decoded_t    ex_q;
    logic [31:0] op_b;
    logic [31:0] alu_res;
    logic [31:0] pc_plus_4;
    logic        is_ctrl;
    logic        taken;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_out.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_out.valid) begin
            ex_q <= dec_out;
        end
    end

    // Second operand is either rs2 or the immediate
    assign op_b = ex_q.use_imm ? ex_q.imm : ex_q.rs2_val;

    always_comb begin
        case (ex_q.alu_op)
            ALU_ADD:    alu_res = ex_q.rs1_val + op_b;
            ALU_SUB:    alu_res = ex_q.rs1_val - op_b;
            ALU_AND:    alu_res = ex_q.rs1_val & op_b;
            ALU_OR:     alu_res = ex_q.rs1_val | op_b;
            ALU_XOR:    alu_res = ex_q.rs1_val ^ op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_b;
        endcase
    end

    assign pc_plus_4 = ex_q.pc + 32'd4;
    assign is_ctrl   = ex_q.is_branch_eq || ex_q.is_branch_ne || ex_q.is_jal;

    // Branch compare
    assign taken = ex_valid &&
                   ((ex_q.is_branch_eq && (ex_q.rs1_val == ex_q.rs2_val)) ||
                    (ex_q.is_branch_ne && (ex_q.rs1_val != ex_q.rs2_val)) ||
                    ex_q.is_jal);

    // Redirect for exactly the cycle the item sits here
    assign e2f_cmd        = taken ? E2F_CMD_BRANCHTAKEN : E2F_CMD_NONE;
    assign e2f_target     = ex_q.pc + ex_q.imm;
    assign exec_busy_ctrl = ex_valid && is_ctrl;

    always_comb begin
        exec_out.valid   = ex_valid;
        exec_out.pc      = ex_q.pc;
        exec_out.rd      = ex_q.rd;
        // JAL links the return address
        exec_out.wdata   = ex_q.is_jal ? pc_plus_4 : alu_res;
        exec_out.is_trap = ex_q.exc_start;
        exec_out.cause   = ex_q.cause;
    end

    // Hazard stall leaves execute empty right behind a redirect
    assert property (@(posedge clk) disable iff (!rst_n)
        (e2f_cmd == E2F_CMD_BRANCHTAKEN) |=> !ex_valid);

endmodule

// File: verilog/result_writeback.sv
`timescale 1ns/1ps

module result_writeback (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::exec_out_t exec_out,
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,
    output logic [31:0]         rs1_data,
    output logic [31:0]         rs2_data,
    output core_pkg::retire_t   retire
);
    import core_pkg::*;

    // x1 to x31, x0 is hardwired
    logic [31:0] regs [1:31];
    logic        wr_en;
    logic        ret_valid;
    retire_t     ret_q;

    // Traps and x0 targets never write
    assign wr_en = exec_out.valid && !exec_out.is_trap && (exec_out.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[exec_out.rd] <= exec_out.wdata;
        end
    end

    // Read with same-cycle write forwarding
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            read_port = 32'd0;
        end else if (wr_en && (addr == exec_out.rd)) begin
            read_port = exec_out.wdata;
        end else begin
            read_port = regs[addr];
        end
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    // Retire report one cycle after execute
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ret_valid <= 1'b0;
        end else begin
            ret_valid <= exec_out.valid;
        end
    end

    always_ff @(posedge clk) begin
        ret_q <= exec_out;
    end

    always_comb begin
        retire       = ret_q;
        retire.valid = ret_valid;
    end

endmodule

// File: verilog/core_top.sv
`timescale 1ns/1ps

module core_top #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [31:0]           csr_mtvec,
    input  logic                  irq_timer,
    input  logic                  irq_exti,
    input  logic                  irq_timer_en,
    input  logic                  irq_exti_en,
    output core_pkg::cache_cmd_t  c_cmd,
    output logic [31:0]           c_address,
    input  core_pkg::cache_resp_t c_response,
    input  logic [31:0]           c_load_data,
    input  logic                  c_reset_done,
    output core_pkg::retire_t     retire
);
    import core_pkg::*;

    fetch_out_t  fetch_out;
    decoded_t    dec_out;
    exec_out_t   exec_out;
    e2f_cmd_t    e2f_cmd;
    logic        e2f_ready;
    logic [31:0] e2f_target;
    logic        exec_busy_ctrl;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    // PC, cache commands and trap entry
    fetch_unit #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .csr_mtvec    (csr_mtvec),
        .irq_timer    (irq_timer),
        .irq_exti     (irq_exti),
        .irq_timer_en (irq_timer_en),
        .irq_exti_en  (irq_exti_en),
        .c_response   (c_response),
        .c_reset_done (c_reset_done),
        .c_load_data  (c_load_data),
        .c_cmd        (c_cmd),
        .c_address    (c_address),
        .fetch_out    (fetch_out),
        .e2f_ready    (e2f_ready),
        .e2f_cmd      (e2f_cmd),
        .e2f_target   (e2f_target)
    );

    instr_decode u_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_out      (fetch_out),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .exec_busy_ctrl (exec_busy_ctrl),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .dec_out        (dec_out),
        .e2f_ready      (e2f_ready)
    );

    execute_alu u_execute (
        .clk            (clk),
        .rst_n          (rst_n),
        .dec_out        (dec_out),
        .exec_out       (exec_out),
        .exec_busy_ctrl (exec_busy_ctrl),
        .e2f_cmd        (e2f_cmd),
        .e2f_target     (e2f_target)
    );

    // Register file and retire report
    result_writeback u_result (
        .clk      (clk),
        .rst_n    (rst_n),
        .exec_out (exec_out),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .retire   (retire)
    );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD_NS = 4
) (
    output logic clk
);

    // Free-running clock, 8 ns period by default
    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD_NS) clk = ~clk;

endmodule

// File: tests/tb_core.sv
`timescale 1ns/1ps

module tb_core;
    import core_pkg::*;

    localparam logic [31:0] RESET_VECTOR = 32'h0000_0100;
    localparam string       GOLDEN_FILE  = "tests/core_golden.txt";

    logic        clk;
    logic        rst_n;
    logic [31:0] csr_mtvec;
    logic        irq_timer;
    logic        irq_exti;
    logic        irq_timer_en;
    logic        irq_exti_en;
    cache_cmd_t  c_cmd;
    logic [31:0] c_address;
    cache_resp_t c_response;
    logic [31:0] c_load_data;
    logic        c_reset_done;
    retire_t     retire;

    // Golden memory image and event points
    logic [31:0] mem [logic [31:0]];
    logic [3:0]  fault_at [logic [31:0]];
    // 1 for timer, 2 for external
    logic [1:0]  irq_at [logic [31:0]];
    retire_t     exp_q [$];
    int          exp_idx;

    // Cache model state
    integer      seed;
    cache_cmd_t  cmd_seen;
    logic [31:0] addr_seen;
    logic        busy;
    logic [31:0] busy_addr;
    int          waits_left;
    int          reset_wait;
    logic        fetch_started;
    logic        drop_timer;
    logic        drop_exti;

    tb_clock u_clock (
        .clk (clk)
    );

    core_top #(
        .RESET_VECTOR (RESET_VECTOR)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .csr_mtvec    (csr_mtvec),
        .irq_timer    (irq_timer),
        .irq_exti     (irq_exti),
        .irq_timer_en (irq_timer_en),
        .irq_exti_en  (irq_exti_en),
        .c_cmd        (c_cmd),
        .c_address    (c_address),
        .c_response   (c_response),
        .c_load_data  (c_load_data),
        .c_reset_done (c_reset_done),
        .retire       (retire)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_retire(input retire_t got, input retire_t exp);
        if (got.pc !== exp.pc) begin
            report_failure($sformatf("FAIL %0t retire.pc got %h expected %h",
                                     $time, got.pc, exp.pc));
        end
        if (got.is_trap !== exp.is_trap) begin
            report_failure($sformatf("FAIL %0t retire.is_trap got %b expected %b",
                                     $time, got.is_trap, exp.is_trap));
        end
        // Register result only matters for a real write
        if (!exp.is_trap && (got.rd !== exp.rd)) begin
            report_failure($sformatf("FAIL %0t retire.rd got %0d expected %0d",
                                     $time, got.rd, exp.rd));
        end
        if (!exp.is_trap && (exp.rd != 5'd0) && (got.wdata !== exp.wdata)) begin
            report_failure($sformatf("FAIL %0t retire.wdata got %h expected %h",
                                     $time, got.wdata, exp.wdata));
        end
    endtask

    task automatic compare_cause(input trap_cause_t got, input trap_cause_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAIL %0t retire.cause got %0d expected %0d",
                                     $time, got, exp));
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        byte         tag;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        retire_t     rec;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            report_failure("could not open the golden file");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if ((n > 0) && (line.len() > 1)) begin
                tag = line.getc(0);
                a = 32'd0;
                b = 32'd0;
                c = 32'd0;
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
                rec = '0;
                rec.valid = 1'b1;
                rec.pc = a;
                case (tag)
                    "V": csr_mtvec = a;
                    "M": mem[a] = b;
                    "F": fault_at[a] = b[3:0];
                    "T": irq_at[a] = 2'd1;
                    "X": irq_at[a] = 2'd2;
                    "R": begin
                        rec.rd = b[4:0];
                        rec.wdata = c;
                        exp_q.push_back(rec);
                    end
                    "P": begin
                        rec.is_trap = 1'b1;
                        rec.cause = trap_cause_t'(b[3:0]);
                        exp_q.push_back(rec);
                    end
                    default: begin
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    // One retire record against the next expected one
    task automatic check_next_retire();
        if (!fetch_started) begin
            report_failure("a retire appeared before the first fetch from the reset vector");
        end
        if (exp_idx < exp_q.size()) begin
            compare_retire(retire, exp_q[exp_idx]);
            if (exp_q[exp_idx].is_trap) begin
                compare_cause(retire.cause, exp_q[exp_idx].cause);
            end
            exp_idx++;
        end
        // Interrupt line falls once its trap has retired
        if (retire.is_trap && (retire.cause == TIMER_IRQ)) begin
            drop_timer = 1'b1;
        end
        if (retire.is_trap && (retire.cause == EXTERNAL_IRQ)) begin
            drop_exti = 1'b1;
        end
    endtask

    // Answer for the pending command, if any
    task automatic answer_cache();
        c_load_data = 32'd0;
        if (!busy) begin
            c_response = CACHE_RESP_IDLE;
        end else if ((waits_left > 0) || irq_timer || irq_exti) begin
            // Held off while an interrupt is still pending
            c_response = CACHE_RESP_WAIT;
            if (waits_left > 0) begin
                waits_left--;
            end
        end else begin
            busy = 1'b0;
            if (fault_at.exists(busy_addr)) begin
                if (fault_at[busy_addr] == 4'd0) begin
                    c_response = CACHE_RESP_MISALIGNED;
                end else begin
                    c_response = CACHE_RESP_ACCESSFAULT;
                end
            end else begin
                c_response = CACHE_RESP_DONE;
                if (mem.exists(busy_addr)) begin
                    c_load_data = mem[busy_addr];
                end else begin
                    c_load_data = NOP_INSTR;
                end
                // Each interrupt point fires once
                if (irq_at.exists(busy_addr)) begin
                    if (irq_at[busy_addr] == 2'd1) begin
                        irq_timer = 1'b1;
                    end else begin
                        irq_exti = 1'b1;
                    end
                    irq_at.delete(busy_addr);
                end
            end
        end
    endtask

    // Command, address and retire are stable by the falling edge
    always @(negedge clk) begin
        cmd_seen  = c_cmd;
        addr_seen = c_address;
        if (rst_n && retire.valid) begin
            check_next_retire();
        end
    end

    // Cache model and interrupt driver, 1 ns after the rising edge
    always @(posedge clk) begin
        #1;
        if (!rst_n) begin
            c_response   = CACHE_RESP_IDLE;
            c_load_data  = 32'd0;
            c_reset_done = 1'b0;
            busy         = 1'b0;
            reset_wait   = 0;
        end else begin
            // Cache tag clear takes a few cycles
            if (reset_wait < 3) begin
                reset_wait++;
            end else begin
                c_reset_done = 1'b1;
            end
            if (drop_timer) begin
                irq_timer  = 1'b0;
                drop_timer = 1'b0;
            end
            if (drop_exti) begin
                irq_exti  = 1'b0;
                drop_exti = 1'b0;
            end
            if (cmd_seen == CACHE_CMD_EXECUTE) begin
                if (!fetch_started && (addr_seen != RESET_VECTOR)) begin
                    report_failure("first fetch did not go to the reset vector");
                end
                fetch_started = 1'b1;
                busy          = 1'b1;
                busy_addr     = addr_seen;
                waits_left    = $unsigned($random(seed)) % 4;
            end
            answer_cache();
        end
    end

    // Watchdog scaled to the number of expected records
    initial begin
        @(posedge rst_n);
        repeat (40 * exp_q.size() + 8) @(posedge clk);
        report_failure("timeout while waiting for the expected retire records");
    end

    initial begin
        seed          = 32'hb30cd00d;
        rst_n         = 1'b0;
        csr_mtvec     = 32'd0;
        irq_timer     = 1'b0;
        irq_exti      = 1'b0;
        irq_timer_en  = 1'b1;
        irq_exti_en   = 1'b1;
        c_response    = CACHE_RESP_IDLE;
        c_load_data   = 32'd0;
        c_reset_done  = 1'b0;
        cmd_seen      = CACHE_CMD_NONE;
        addr_seen     = 32'd0;
        busy          = 1'b0;
        busy_addr     = 32'd0;
        waits_left    = 0;
        reset_wait    = 0;
        fetch_started = 1'b0;
        drop_timer    = 1'b0;
        drop_exti     = 1'b0;
        exp_idx       = 0;
        load_golden();
        if (exp_q.size() == 0) begin
            report_failure("golden file holds no expected records");
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        while (exp_idx < exp_q.size()) begin
            @(posedge clk);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// File: tests/core_golden.txt
# V mtvec | M addr word | F addr kind(0 misaligned, 1 access) | T/X addr of irq DONE
# R pc rd wdata (expected retire) | P pc cause (expected trap)
V 00000200
M 00000100 00500093
M 00000104 ffd08113
M 00000108 002081b3
M 0000010c 40110233
M 00000110 0041f2b3
M 00000114 0020e333
M 00000118 0061c3b3
M 0000011c 12345437
M 00000120 0000007f
M 00000124 00038663
M 00000128 00100493
M 00000130 00109463
M 00000134 00c0066f
M 00000138 00300493
M 00000140 00000513
M 00000144 00100593
M 00000148 00700693
M 00000200 00150513
M 00000204 0eb50e63
M 00000208 1380006f
M 00000300 00900793
M 00000304 0017c833
F 00000340 1
T 00000148
X 00000304
R 00000100 01 00000005
R 00000104 02 00000002
R 00000108 03 00000007
R 0000010c 04 fffffffd
R 00000110 05 00000005
R 00000114 06 00000007
R 00000118 07 00000000
R 0000011c 08 12345000
R 00000120 00 00000000
R 00000124 00 00000000
R 00000130 00 00000000
R 00000134 0c 00000138
R 00000140 0a 00000000
R 00000144 0b 00000001
P 00000148 7
R 00000200 0a 00000001
R 00000204 00 00000000
R 00000300 0f 00000009
P 00000304 b
R 00000200 0a 00000002
R 00000204 00 00000000
R 00000208 00 00000000
P 00000340 1
R 00000200 0a 00000003

// File: all.f
common/core_pkg.sv
fetch/fetch_unit.sv
verilog/instr_decode.sv
verilog/execute_alu.sv
verilog/result_writeback.sv
verilog/core_top.sv
tests/tb_clock.sv
tests/tb_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_core -f all.f -o sim_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_core 2>&1)
sim_rc=$?
echo "$sim_out"
if [ $sim_rc -ne 0 ]; then
    echo "Simulation exited with status $sim_rc"
    exit 1
fi

if echo "$sim_out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
